//--- Bender.yml
package:
  name: exec_backend

sources:
  - include_dirs:
      - logic
    files:
      - logic/exec_pkg.sv
      - logic/ex1_stage.sv
      - logic/ex1_ex2_reg.sv
      - logic/ex2_stage.sv
      - logic/exec_top.sv
      - target: test
        include_dirs:
          - logic
        files:
          - tests/tb_exec.sv

//--- logic/ex1_ex2_reg.sv
`timescale 1ns/10ps

module ex1_ex2_reg (
    input  logic                      clk,
    input  logic                      aresetn,
    input  logic                      flush,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  exec_pkg::ex1_lane_t [1:0] in_data,
    output logic                      out_valid,
    input  logic                      out_ready,
    output exec_pkg::ex1_lane_t [1:0] out_data
);
    import exec_pkg::*;

    ex1_lane_t [1:0] data_q;
    logic [1:0]      lane_vld_q;
    logic            valid_q;
    logic            load;

    // Can take a new bundle while the held one leaves.
    assign in_ready  = !valid_q || out_ready;
    assign load      = in_valid && in_ready && !flush;
    assign out_valid = valid_q;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            valid_q    <= 1'b0;
            lane_vld_q <= '0;
        end else if (flush) begin
            valid_q    <= 1'b0;
            lane_vld_q <= '0;
        end else if (load) begin
            valid_q    <= 1'b1;
            lane_vld_q <= {in_data[1].lane_valid, in_data[0].lane_valid};
        end else if (out_ready) begin
            valid_q    <= 1'b0;   // Drained.
            lane_vld_q <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            data_q <= in_data;
        end
    end

    always_comb begin
        out_data = data_q;
        for (int i = 0; i < 2; i++) begin
            out_data[i].lane_valid = lane_vld_q[i];
        end
    end

    // ******************************
    // Checks
    // ******************************

    assert property (@(posedge clk) disable iff (!aresetn)
        out_valid && !out_ready && !flush |=> out_valid && $stable(out_data))
        else $error("ex1_ex2_reg: held bundle changed during stall");

    assert property (@(posedge clk) disable iff (!aresetn)
        flush |=> !out_valid)
        else $error("ex1_ex2_reg: bundle survived a flush");

endmodule

//--- logic/ex1_stage.sv
`timescale 1ns/10ps
`include "exec_settings.svh"

module ex1_stage (
    input  logic                      clk,
    input  logic                      aresetn,
    input  logic                      flush,
    input  logic                      issue_valid,
    output logic                      issue_ready,
    input  exec_pkg::issue_lane_t [1:0] issue,
    output logic                      ex1_valid,
    input  logic                      ex1_ready,
    output exec_pkg::ex1_lane_t [1:0] ex1_out
);
    import exec_pkg::*;

    localparam int SH_W = $clog2(`XLEN);
    localparam int HALF = `XLEN / 2;

    function automatic logic [`XLEN-1:0] alu_eval(alu_op_e op, logic [`XLEN-1:0] a,
                                                 logic [`XLEN-1:0] b);
        logic [`XLEN-1:0] res;
        res = '0;
        case (op)
            alu_add:  res = a + b;
            alu_sub:  res = a - b;
            alu_and:  res = a & b;
            alu_or:   res = a | b;
            alu_xor:  res = a ^ b;
            alu_nor:  res = ~(a | b);
            alu_sll:  res = a << b[SH_W-1:0];
            alu_srl:  res = a >> b[SH_W-1:0];
            alu_sra:  res = $signed(a) >>> b[SH_W-1:0];
            alu_slt:  res[0] = $signed(a) < $signed(b);
            alu_sltu: res[0] = a < b;
            alu_lui:  res = b;  // Immediate comes in already shifted.
            default:  res = '0;
        endcase
        return res;
    endfunction

    // Stage is combinational, flush only blocks the handshake.
    assign ex1_valid   = issue_valid && !flush;
    assign issue_ready = ex1_ready && !flush;

    always_comb begin
        logic [`XLEN-1:0] op_b;
        logic [HALF-1:0]  a_hi;
        logic [HALF-1:0]  a_lo;
        logic [HALF-1:0]  b_hi;
        logic [HALF-1:0]  b_lo;
        logic [`XLEN-1:0] corr_a;
        logic [`XLEN-1:0] corr_b;
        for (int i = 0; i < 2; i++) begin
            op_b = issue[i].uop.alu.use_imm ? issue[i].imm : issue[i].src2;

            ex1_out[i].lane_valid = issue[i].lane_valid;
            ex1_out[i].pc         = issue[i].pc;
            ex1_out[i].uop        = issue[i].uop;
            ex1_out[i].is_alu     = issue[i].is_alu;
            ex1_out[i].rd         = issue[i].rd;
            ex1_out[i].alu_data   = alu_eval(issue[i].uop.alu.op, issue[i].src1, op_b);

            // ******************************
            // Multiply, first half
            // ******************************
            a_hi = issue[i].src1[`XLEN-1:HALF];
            a_lo = issue[i].src1[HALF-1:0];
            b_hi = issue[i].src2[`XLEN-1:HALF];
            b_lo = issue[i].src2[HALF-1:0];
            ex1_out[i].pp_hh = a_hi * b_hi;
            ex1_out[i].pp_hl = a_hi * b_lo;
            ex1_out[i].pp_lh = a_lo * b_hi;
            ex1_out[i].pp_ll = a_lo * b_lo;

            // A negative signed operand subtracts the other operand from the high word.
            corr_a = (issue[i].uop.mul.src1_signed && issue[i].src1[`XLEN-1]) ?
                     issue[i].src2 : '0;
            corr_b = (issue[i].uop.mul.src2_signed && issue[i].src2[`XLEN-1]) ?
                     issue[i].src1 : '0;
            ex1_out[i].mul_comp = -(corr_a + corr_b);

            if (!issue[i].lane_valid)
                ex1_out[i].exc = exc_none;
            else if (issue[i].is_syscall)
                ex1_out[i].exc = exc_syscall;
            else if (issue[i].is_break)
                ex1_out[i].exc = exc_break;
            else if (issue[i].is_priviledged)
                ex1_out[i].exc = exc_privileged;
            else
                ex1_out[i].exc = exc_none;
        end
    end

    // Decode never pairs two syscalls in one bundle.
    assert property (@(posedge clk) disable iff (!aresetn)
        issue_valid |-> !(issue[0].lane_valid && issue[0].is_syscall &&
                          issue[1].lane_valid && issue[1].is_syscall))
        else $error("ex1_stage: syscall on both lanes");

endmodule

//--- logic/ex2_stage.sv
`timescale 1ns/10ps
`include "exec_settings.svh"

module ex2_stage (
    input  logic                      clk,
    input  logic                      aresetn,
    input  logic                      flush,
    input  logic                      ex2_valid,
    output logic                      ex2_ready,
    input  exec_pkg::ex1_lane_t [1:0] ex2_in,
    output logic                      wb_valid,
    input  logic                      wb_ready,
    output exec_pkg::wb_lane_t [1:0]  wb
);
    import exec_pkg::*;

    wb_lane_t [1:0] wb_next;
    wb_lane_t [1:0] wb_q;
    logic [1:0]     wen_q;
    logic           wb_valid_q;
    logic           load;
    logic           lane0_exc;

    function automatic logic [`XLEN-1:0] mul_finish(ex1_lane_t l);
        logic [2*`XLEN-1:0] prod;
        logic [`XLEN-1:0]   hi;
        // pp_hh and pp_ll do not overlap, so they concatenate.
        prod = {l.pp_hh, l.pp_ll}
             + ({{`XLEN{1'b0}}, l.pp_hl} << (`XLEN / 2))
             + ({{`XLEN{1'b0}}, l.pp_lh} << (`XLEN / 2));
        hi = prod[2*`XLEN-1:`XLEN];
        if (l.uop.mul.op == mulh_w)
            hi = hi + l.mul_comp;
        return (l.uop.mul.op == mul_w) ? prod[`XLEN-1:0] : hi;
    endfunction

    assign ex2_ready = !wb_valid_q || wb_ready;
    assign load      = ex2_valid && ex2_ready && !flush;
    assign lane0_exc = ex2_in[0].lane_valid && (ex2_in[0].exc != exc_none);

    // ******************************
    // Result select and squash
    // ******************************
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            wb_next[i].rd   = ex2_in[i].rd;
            wb_next[i].pc   = ex2_in[i].pc;
            wb_next[i].data = ex2_in[i].is_alu ? ex2_in[i].alu_data : mul_finish(ex2_in[i]);
            wb_next[i].exc  = ex2_in[i].lane_valid ? ex2_in[i].exc : exc_none;
            wb_next[i].wen  = ex2_in[i].lane_valid && (ex2_in[i].exc == exc_none) &&
                              (ex2_in[i].rd != '0);
        end
        // Younger lane dies behind an older exception.
        if (lane0_exc) begin
            wb_next[1].exc = exc_none;
            wb_next[1].wen = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            wb_valid_q <= 1'b0;
            wen_q      <= '0;
        end else if (flush) begin
            wb_valid_q <= 1'b0;
            wen_q      <= '0;
        end else if (load) begin
            wb_valid_q <= 1'b1;
            wen_q      <= {wb_next[1].wen, wb_next[0].wen};
        end else if (wb_ready) begin
            wb_valid_q <= 1'b0;
            wen_q      <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            wb_q <= wb_next;
        end
    end

    always_comb begin
        wb = wb_q;
        for (int i = 0; i < 2; i++) begin
            wb[i].wen = wen_q[i];
        end
    end

    assign wb_valid = wb_valid_q;

    assert property (@(posedge clk) disable iff (!aresetn)
        wb_valid && !wb_ready && !flush |=> wb_valid && $stable(wb))
        else $error("ex2_stage: writeback dropped under back-pressure");

endmodule

//--- logic/exec_pkg.sv
`include "exec_settings.svh"

package exec_pkg;

    // ******************************
    // Micro-op encodings
    // ******************************

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor,
        alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu, alu_lui
    } alu_op_e;

    typedef enum logic [1:0] {
        mul_w,    // Low word.
        mulh_w,   // Signed high word.
        mulh_wu   // Unsigned high word.
    } mul_op_e;

    typedef enum logic [1:0] {
        exc_none, exc_syscall, exc_break, exc_privileged
    } exc_e;

    typedef struct packed {
        logic [`UOP_W-6:0] spare;
        logic              use_imm;
        alu_op_e           op;
    } uop_alu_t;

    typedef struct packed {
        logic [`UOP_W-5:0] spare;
        logic              src2_signed;
        logic              src1_signed;
        mul_op_e           op;
    } uop_mul_t;

    // The lane's is_alu flag selects the view.
    typedef union packed {
        uop_alu_t alu;
        uop_mul_t mul;
    } uop_t;

    // ******************************
    // Stage bundles, one lane each
    // ******************************

    typedef struct packed {
        logic               lane_valid;
        logic [`XLEN-1:0]   pc;
        logic               is_alu;
        logic               is_syscall;
        logic               is_break;
        logic               is_priviledged;
        uop_t               uop;
        logic [`XLEN-1:0]   imm;
        logic [`XLEN-1:0]   src1;
        logic [`XLEN-1:0]   src2;
        logic [`REG_AW-1:0] rd;
    } issue_lane_t;

    typedef struct packed {
        logic               lane_valid;
        logic [`XLEN-1:0]   pc;
        exc_e               exc;
        uop_t               uop;
        logic               is_alu;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   alu_data;
        logic [`XLEN-1:0]   pp_hh;
        logic [`XLEN-1:0]   pp_hl;
        logic [`XLEN-1:0]   pp_lh;
        logic [`XLEN-1:0]   pp_ll;
        logic [`XLEN-1:0]   mul_comp;  // Signed correction for the high word.
    } ex1_lane_t;

    typedef struct packed {
        logic               wen;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   data;
        exc_e               exc;
        logic [`XLEN-1:0]   pc;
    } wb_lane_t;

endpackage

//--- logic/exec_settings.svh
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// Data word width.
`define XLEN 32

// Register address width.
`define REG_AW 5

// Micro-op word width.
`define UOP_W 8

`endif

//--- logic/exec_top.sv
`timescale 1ns/10ps

module exec_top (
    input  logic                        clk,
    input  logic                        aresetn,
    input  logic                        flush,
    input  logic                        issue_valid,
    output logic                        issue_ready,
    input  exec_pkg::issue_lane_t [1:0] issue,
    output logic                        wb_valid,
    input  logic                        wb_ready,
    output exec_pkg::wb_lane_t [1:0]    wb
);
    import exec_pkg::*;

    logic            ex1_valid;
    logic            ex1_ready;
    ex1_lane_t [1:0] ex1_out;
    logic            ex2_valid;
    logic            ex2_ready;
    ex1_lane_t [1:0] ex2_in;

    ex1_stage ex1_stage0 (
        .clk         (clk),
        .aresetn     (aresetn),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue       (issue),
        .ex1_valid   (ex1_valid),
        .ex1_ready   (ex1_ready),
        .ex1_out     (ex1_out)
    );

    ex1_ex2_reg ex1_ex2_reg0 (
        .clk       (clk),
        .aresetn   (aresetn),
        .flush     (flush),
        .in_valid  (ex1_valid),
        .in_ready  (ex1_ready),
        .in_data   (ex1_out),
        .out_valid (ex2_valid),
        .out_ready (ex2_ready),
        .out_data  (ex2_in)
    );

    ex2_stage ex2_stage0 (
        .clk       (clk),
        .aresetn   (aresetn),
        .flush     (flush),
        .ex2_valid (ex2_valid),
        .ex2_ready (ex2_ready),
        .ex2_in    (ex2_in),
        .wb_valid  (wb_valid),
        .wb_ready  (wb_ready),
        .wb        (wb)
    );

endmodule

//--- sim.f
+incdir+logic
logic/exec_pkg.sv
logic/ex1_stage.sv
logic/ex1_ex2_reg.sv
logic/ex2_stage.sv
logic/exec_top.sv
tests/tb_exec.sv

//--- tests/tb_exec.sv
`timescale 1ns/10ps
`include "exec_settings.svh"

module tb_exec;
    import exec_pkg::*;

    typedef issue_lane_t [1:0] issue_pair_t;
    typedef wb_lane_t [1:0]    wb_pair_t;

    localparam int TIMEOUT = 200;  // Cycles per wait.

    logic        clk;
    logic        aresetn;
    logic        flush;
    logic        issue_valid;
    logic        issue_ready;
    issue_pair_t issue;
    logic        wb_valid;
    logic        wb_ready;
    wb_pair_t    wb;

    wb_pair_t exp_q[$];    // Expected writebacks in issue order.
    int       exp_cyc[$];  // Issue cycle of each expected bundle.
    int       cyc;
    int       in_flight;
    int       n_checks;
    int       n_errors;
    bit       check_latency;
    bit       timed_out;
    bit       bp_active;

    exec_top dut0 (
        .clk         (clk),
        .aresetn     (aresetn),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue       (issue),
        .wb_valid    (wb_valid),
        .wb_ready    (wb_ready),
        .wb          (wb)
    );

    always #4 clk = ~clk;

    // ******************************
    // Reference model
    // ******************************

    function automatic logic [`XLEN-1:0] ref_alu(alu_op_e op, logic [`XLEN-1:0] a,
                                                 logic [`XLEN-1:0] b);
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_nor:  return ~(a | b);
            alu_sll:  return a << b[4:0];
            alu_srl:  return a >> b[4:0];
            alu_sra:  return $signed(a) >>> b[4:0];
            alu_slt:  return ($signed(a) < $signed(b)) ? 1 : 0;
            alu_sltu: return (a < b) ? 1 : 0;
            alu_lui:  return b;
            default:  return '0;
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] ref_mul(mul_op_e op, logic [`XLEN-1:0] a,
                                                 logic [`XLEN-1:0] b);
        logic [2*`XLEN-1:0] sprod;
        logic [2*`XLEN-1:0] uprod;
        // Sign extended operands give the signed product modulo 2**64.
        sprod = {{`XLEN{a[`XLEN-1]}}, a} * {{`XLEN{b[`XLEN-1]}}, b};
        uprod = {{`XLEN{1'b0}}, a} * {{`XLEN{1'b0}}, b};
        case (op)
            mul_w:   return uprod[`XLEN-1:0];
            mulh_w:  return sprod[2*`XLEN-1:`XLEN];
            default: return uprod[2*`XLEN-1:`XLEN];
        endcase
    endfunction

    function automatic wb_pair_t ref_pair(issue_pair_t in);
        wb_pair_t         r;
        logic [`XLEN-1:0] op_b;
        for (int i = 0; i < 2; i++) begin
            op_b       = in[i].uop.alu.use_imm ? in[i].imm : in[i].src2;
            r[i].rd    = in[i].rd;
            r[i].pc    = in[i].pc;
            r[i].data  = in[i].is_alu ? ref_alu(in[i].uop.alu.op, in[i].src1, op_b) :
                                        ref_mul(in[i].uop.mul.op, in[i].src1, in[i].src2);
            if (!in[i].lane_valid)
                r[i].exc = exc_none;
            else if (in[i].is_syscall)
                r[i].exc = exc_syscall;
            else if (in[i].is_break)
                r[i].exc = exc_break;
            else if (in[i].is_priviledged)
                r[i].exc = exc_privileged;
            else
                r[i].exc = exc_none;
            r[i].wen = in[i].lane_valid && (r[i].exc == exc_none) && (in[i].rd != 0);
        end
        if (r[0].exc != exc_none) begin  // Older exception kills lane 1.
            r[1].exc = exc_none;
            r[1].wen = 1'b0;
        end
        return r;
    endfunction

    // ******************************
    // Stimulus builders
    // ******************************

    function automatic issue_lane_t make_lane(bit is_alu_op, int op, logic [`XLEN-1:0] a,
                                              logic [`XLEN-1:0] b);
        issue_lane_t l;
        l            = '0;
        l.lane_valid = 1'b1;
        l.pc         = $urandom & 32'hffff_fffc;
        l.is_alu     = is_alu_op;
        l.imm        = $urandom;
        l.src1       = a;
        l.src2       = b;
        l.rd         = 1 + ($urandom % 31);
        if (is_alu_op) begin
            l.uop.alu.op = alu_op_e'(op);
        end else begin
            l.uop.mul.op          = mul_op_e'(op);
            l.uop.mul.src1_signed = (mul_op_e'(op) != mulh_wu);
            l.uop.mul.src2_signed = (mul_op_e'(op) != mulh_wu);
        end
        return l;
    endfunction

    function automatic issue_pair_t random_pair();
        issue_pair_t p;
        for (int i = 0; i < 2; i++) begin
            if ($urandom % 2) begin
                p[i] = make_lane(1'b1, $urandom % 12, $urandom, $urandom);
                p[i].uop.alu.use_imm = $urandom % 2;
            end else begin
                p[i] = make_lane(1'b0, $urandom % 3, $urandom, $urandom);
            end
        end
        return p;
    endfunction

    // ******************************
    // Reporting and handshakes
    // ******************************

    task automatic report_error(string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        n_errors++;
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0 && !timed_out)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    endtask

    task automatic give_up(string what);
        $display("Timeout while waiting for %s.", what);
        timed_out = 1'b1;
        finish_run();
    endtask

    // Called and returns just after a falling edge.
    task automatic send_bundle(issue_pair_t b, bit expect_wb);
        int waited;
        waited      = 0;
        issue       = b;
        issue_valid = 1'b1;
        @(posedge clk);
        while (!issue_ready) begin
            waited++;
            if (waited > TIMEOUT)
                give_up("issue_ready");
            @(posedge clk);
        end
        if (expect_wb) begin
            exp_q.push_back(ref_pair(b));
            exp_cyc.push_back(cyc);
        end
        @(negedge clk);
        issue_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > TIMEOUT)
                give_up("the outstanding writebacks");
            @(posedge clk);
        end
        @(negedge clk);
    endtask

    // Scoreboard and occupancy checks.
    always @(posedge clk) begin
        wb_pair_t want;
        int       lat;
        if (aresetn) begin
            if (flush && issue_ready)
                report_error("issue_ready high during flush");
            if (in_flight == 2 && !wb_ready && issue_ready)
                report_error("issue_ready high with two bundles held");
            if (wb_valid && wb_ready) begin
                n_checks++;
                if (exp_q.size() == 0) begin
                    report_error("writeback with no bundle outstanding");
                end else begin
                    want = exp_q.pop_front();
                    lat  = cyc - exp_cyc.pop_front();
                    if (wb !== want)
                        report_error($sformatf("wb %h, expected %h", wb, want));
                    if (check_latency && lat != 2)
                        report_error($sformatf("writeback after %0d cycles, expected 2", lat));
                end
            end
            if (flush)
                in_flight = 0;
            else
                in_flight = in_flight + int'(issue_valid && issue_ready)
                                      - int'(wb_valid && wb_ready);
            if (in_flight > 2)
                report_error($sformatf("%0d bundles in flight", in_flight));
        end
        cyc <= cyc + 1;
    end

    // ******************************
    // Directed tests
    // ******************************

    task automatic test_alu();
        issue_pair_t p;
        check_latency = 1'b1;
        for (int op = 0; op < 12; op++) begin
            for (int imm = 0; imm < 2; imm++) begin
                for (int i = 0; i < 2; i++) begin
                    p[i] = make_lane(1'b1, op, $urandom, $urandom);
                    p[i].uop.alu.use_imm = imm[0];
                end
                send_bundle(p, 1'b1);
            end
        end
        wait_drain();
        check_latency = 1'b0;
    endtask

    task automatic test_mul();
        logic [`XLEN-1:0] corner [5];
        issue_pair_t      p;
        corner = '{32'h0, 32'hffff_ffff, 32'h8000_0000, 32'h1, 32'h7fff_ffff};
        for (int op = 0; op < 3; op++) begin
            foreach (corner[a]) begin
                foreach (corner[b]) begin
                    p[0] = make_lane(1'b0, op, corner[a], corner[b]);
                    p[1] = make_lane(1'b0, op, $urandom, $urandom);
                    send_bundle(p, 1'b1);
                end
            end
        end
        wait_drain();
    endtask

    task automatic test_exceptions();
        issue_pair_t p;
        for (int k = 0; k < 4; k++) begin
            p[0] = make_lane(1'b1, alu_add, $urandom, $urandom);
            p[1] = make_lane(1'b1, alu_or, $urandom, $urandom);
            p[0].is_syscall     = (k == 0 || k == 3);
            p[0].is_break       = (k == 1 || k == 3);  // Case 3 checks the priority.
            p[0].is_priviledged = (k == 2);
            send_bundle(p, 1'b1);
        end
        p = random_pair();
        p[1].is_break = 1'b1;  // Lane 0 still writes.
        send_bundle(p, 1'b1);
        p = random_pair();
        p[0].rd = '0;
        p[1].rd = '0;
        send_bundle(p, 1'b1);
        p = random_pair();
        p[1].lane_valid = 1'b0;
        send_bundle(p, 1'b1);
        wait_drain();
    endtask

    task automatic test_backpressure();
        bp_active = 1'b1;
        fork
            begin
                while (bp_active) begin
                    wb_ready = $urandom % 2;
                    @(negedge clk);
                end
            end
            begin
                repeat (40) send_bundle(random_pair(), 1'b1);
                bp_active = 1'b0;
            end
        join
        wb_ready = 1'b1;
        wait_drain();
    endtask

    task automatic test_flush();
        wb_ready = 1'b0;  // Both bundles stay held.
        send_bundle(random_pair(), 1'b0);
        send_bundle(random_pair(), 1'b0);
        flush = 1'b1;
        @(negedge clk);
        wb_ready = 1'b1;
        if (wb_valid)
            report_error("writeback still valid after flush");
        // Second flush cycle on an empty pipeline, with an issue that must be refused.
        issue       = random_pair();
        issue_valid = 1'b1;
        @(negedge clk);
        flush       = 1'b0;
        issue_valid = 1'b0;
        repeat (4) @(negedge clk);
        send_bundle(random_pair(), 1'b1);
        wait_drain();
    endtask

    initial begin
        $timeformat(-9, 1, " ns", 0);
        clk           = 1'b0;
        aresetn       = 1'b0;
        flush         = 1'b0;
        issue_valid   = 1'b0;
        issue         = '0;
        wb_ready      = 1'b1;
        cyc           = 0;
        in_flight     = 0;
        n_checks      = 0;
        n_errors      = 0;
        check_latency = 1'b0;
        timed_out     = 1'b0;
        bp_active     = 1'b0;
        void'($urandom(39));
        repeat (5) @(posedge clk);
        @(negedge clk);
        aresetn = 1'b1;
        if (wb_valid !== 1'b0 || wb[0].wen !== 1'b0 || wb[1].wen !== 1'b0)
            report_error("writeback active after reset");
        test_alu();
        test_mul();
        test_exceptions();
        test_backpressure();
        test_flush();
        finish_run();
    end

endmodule
